/* Makefile */
# Verilator build and run for the issue/execute slice.

TOP := tb_issue_execute

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -Wno-fatal -j 0 -f compile.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* compile.f */
hw/rv_isa_pkg.sv
hw/pipe_ctrl_pkg.sv
hw/pipe_stage.sv
hw/decode.sv
hw/execute.sv
hw/writeback.sv
hw/issue_execute.sv
tests/tb_issue_execute.sv

/* hw/decode.sv */
`timescale 1ns/100ps

module decode import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic                  instr_valid,
    input  logic [xlen-1:0]       instr,
    input  logic [xlen-1:0]       pc,
    input  logic                  predict_taken,
    input  logic [xlen-1:0]       predict_pc,
    input  logic [xlen-1:0]       rdata1,
    input  logic [xlen-1:0]       rdata2,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic [reg_addr_w-1:0] rd,
    output logic [xlen-1:0]       imm,
    output logic [xlen-1:0]       data1,
    output logic [xlen-1:0]       data2,
    output logic [xlen-1:0]       id_pc,
    output logic                  id_predict_taken,
    output logic [xlen-1:0]       id_predict_pc,
    output ex_ctrl_t              ex_ctrl,
    output wb_ctrl_t              wb_ctrl,
    output logic                  valid
);

    logic [2:0]      funct3;
    logic            alt;        // instr[30] selects sub and sra.
    logic [xlen-1:0] imm_i, imm_u, imm_b, imm_j;
    logic [xlen-1:0] imm_sel;
    logic            supported;
    ex_ctrl_t        ex_c;
    wb_ctrl_t        wb_c;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub_sra,
                                        input logic reg_op);
        case (f3)
            f3_add_sub: return (sub_sra && reg_op) ? alu_sub : alu_add;
            f3_sll:     return alu_sll;
            f3_slt:     return alu_slt;
            f3_sltu:    return alu_sltu;
            f3_xor:     return alu_xor;
            f3_srl_sra: return sub_sra ? alu_sra : alu_srl;
            f3_or:      return alu_or;
            default:    return alu_and;
        endcase
    endfunction

    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        supported = 1'b1;
        ex_c      = '0;
        wb_c      = '0;
        imm_sel   = imm_i;
        case (instr[6:0])
            opc_op: begin
                ex_c.alu_op    = alu_sel(funct3, alt, 1'b1);
                wb_c.reg_write = 1'b1;
            end
            opc_op_imm: begin
                ex_c.alu_op    = alu_sel(funct3, alt, 1'b0);
                ex_c.src_b_imm = 1'b1;
                wb_c.reg_write = 1'b1;
            end
            opc_lui: begin
                ex_c.alu_op    = alu_pass_b;
                ex_c.src_b_imm = 1'b1;
                wb_c.reg_write = 1'b1;
                imm_sel        = imm_u;
            end
            opc_auipc: begin
                ex_c.src_a_pc  = 1'b1;
                ex_c.src_b_imm = 1'b1;
                wb_c.reg_write = 1'b1;
                imm_sel        = imm_u;
            end
            opc_branch: begin
                imm_sel = imm_b;
                case (funct3)
                    f3_beq:  ex_c.br_cond = br_eq;
                    f3_bne:  ex_c.br_cond = br_ne;
                    f3_blt:  ex_c.br_cond = br_lt;
                    f3_bge:  ex_c.br_cond = br_ge;
                    f3_bltu: ex_c.br_cond = br_ltu;
                    f3_bgeu: ex_c.br_cond = br_geu;
                    default: supported = 1'b0;
                endcase
            end
            opc_jal: begin
                ex_c.br_cond   = br_jump;
                wb_c.reg_write = 1'b1;
                wb_c.link      = 1'b1;
                imm_sel        = imm_j;
            end
            opc_jalr: begin
                ex_c.br_cond   = br_jump;
                ex_c.jalr      = 1'b1;
                wb_c.reg_write = 1'b1;
                wb_c.link      = 1'b1;
            end
            default: supported = 1'b0;
        endcase
    end

    assign valid = instr_valid && supported;

    // Anything not issued leaves every field at zero.
    assign rs1              = valid ? instr[19:15] : '0;
    assign rs2              = valid ? instr[24:20] : '0;
    assign rd               = valid ? instr[11:7] : '0;
    assign imm              = valid ? imm_sel : '0;
    assign id_pc            = valid ? pc : '0;
    assign id_predict_taken = valid && predict_taken;
    assign id_predict_pc    = valid ? predict_pc : '0;
    assign ex_ctrl          = valid ? ex_c : '0;
    assign wb_ctrl          = valid ? wb_c : '0;

    assign data1 = rdata1; // x0 reads back zero for bubbles.
    assign data2 = rdata2;

endmodule

/* hw/execute.sv */
`timescale 1ns/100ps

module execute import rv_isa_pkg::*, pipe_ctrl_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic [xlen-1:0]       pc,
    input  logic [xlen-1:0]       data1,
    input  logic [xlen-1:0]       data2,
    input  logic [xlen-1:0]       imm,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic [reg_addr_w-1:0] rd,
    input  logic                  predict_taken,
    input  logic [xlen-1:0]       predict_pc,
    input  ex_ctrl_t              ex_ctrl,
    input  wb_ctrl_t              wb_ctrl,
    input  logic                  valid,
    input  logic                  fwd_valid,
    input  logic [reg_addr_w-1:0] fwd_rd,
    input  logic [xlen-1:0]       fwd_data,
    output logic                  redirect,
    output logic [xlen-1:0]       redirect_pc,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic [xlen-1:0]       ex_result,
    output logic                  ex_reg_write
);

    logic [xlen-1:0] src1, src2;
    logic [xlen-1:0] op_a, op_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] cur_pc, seq_pc, target;
    logic            taken;

    // Result stage forwarding; x0 never matches.
    assign src1 = (fwd_valid && fwd_rd != '0 && fwd_rd == rs1) ? fwd_data : data1;
    assign src2 = (fwd_valid && fwd_rd != '0 && fwd_rd == rs2) ? fwd_data : data2;

    assign op_a = ex_ctrl.src_a_pc ? pc : src1;
    assign op_b = ex_ctrl.src_b_imm ? imm : src2;

    always_comb begin
        case (ex_ctrl.alu_op)
            alu_sub:    alu_result = op_a - op_b;
            alu_sll:    alu_result = op_a << op_b[4:0];
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:    alu_result = op_a ^ op_b;
            alu_srl:    alu_result = op_a >> op_b[4:0];
            alu_sra:    alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_or:     alu_result = op_a | op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_pass_b: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    always_comb begin
        case (ex_ctrl.br_cond)
            br_eq:   taken = src1 == src2;
            br_ne:   taken = src1 != src2;
            br_lt:   taken = $signed(src1) < $signed(src2);
            br_ge:   taken = $signed(src1) >= $signed(src2);
            br_ltu:  taken = src1 < src2;
            br_geu:  taken = src1 >= src2;
            br_jump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // A bubble stands for the reset pc.
    assign cur_pc = valid ? pc : reset_pc;
    assign seq_pc = cur_pc + 32'd4;
    assign target = ex_ctrl.jalr ? ((src1 + imm) & ~32'd1) : pc + imm;

    // Wrong direction, or right direction to the wrong place.
    assign redirect = valid && ((taken != predict_taken) ||
                                (taken && target != predict_pc));
    assign redirect_pc = taken ? target : seq_pc;

    assign ex_rd        = rd;
    assign ex_result    = wb_ctrl.link ? seq_pc : alu_result;
    assign ex_reg_write = valid && wb_ctrl.reg_write;

endmodule

/* hw/issue_execute.sv */
`timescale 1ns/100ps

module issue_execute import rv_isa_pkg::*, pipe_ctrl_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  instr_valid,
    input  logic [xlen-1:0]       instr,
    input  logic [xlen-1:0]       pc,
    input  logic                  predict_taken,
    input  logic [xlen-1:0]       predict_pc,
    input  logic                  stall,
    output logic                  redirect,
    output logic [xlen-1:0]       redirect_pc,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data
);

    logic [reg_addr_w-1:0] rs1, rs2, rd;
    logic [xlen-1:0]       rdata1, rdata2;
    logic [xlen-1:0]       imm, data1, data2, id_pc, id_predict_pc;
    logic                  id_predict_taken, id_valid;
    ex_ctrl_t              ex_ctrl;
    wb_ctrl_t              wb_ctrl;
    id_ex_t                id_ex_d, id_ex_q;
    logic [reg_addr_w-1:0] ex_rd, fwd_rd;
    logic [xlen-1:0]       ex_result, fwd_data;
    logic                  ex_reg_write, fwd_valid;

    decode u_decode (
        .instr_valid, .instr, .pc, .predict_taken, .predict_pc, .rdata1, .rdata2,
        .rs1, .rs2, .rd, .imm, .data1, .data2, .id_pc, .id_predict_taken,
        .id_predict_pc, .ex_ctrl, .wb_ctrl, .valid(id_valid)
    );

    assign id_ex_d = '{pc: id_pc, data1: data1, data2: data2, imm: imm, rd: rd,
                       rs1: rs1, rs2: rs2, predict_taken: id_predict_taken,
                       predict_pc: id_predict_pc, ex_ctrl: ex_ctrl, wb_ctrl: wb_ctrl,
                       valid: id_valid};

    pipe_stage #(.payload_t(id_ex_t)) id_ex (
        .clk, .arst_n, .flush(redirect), .stall, .d(id_ex_d), .q(id_ex_q)
    );

    execute #(.reset_pc(reset_pc)) u_execute (
        .pc            (id_ex_q.pc),
        .data1         (id_ex_q.data1),
        .data2         (id_ex_q.data2),
        .imm           (id_ex_q.imm),
        .rs1           (id_ex_q.rs1),
        .rs2           (id_ex_q.rs2),
        .rd            (id_ex_q.rd),
        .predict_taken (id_ex_q.predict_taken),
        .predict_pc    (id_ex_q.predict_pc),
        .ex_ctrl       (id_ex_q.ex_ctrl),
        .wb_ctrl       (id_ex_q.wb_ctrl),
        .valid         (id_ex_q.valid),
        .fwd_valid, .fwd_rd, .fwd_data,
        .redirect, .redirect_pc, .ex_rd, .ex_result, .ex_reg_write
    );

    writeback u_writeback (
        .clk, .arst_n, .stall, .ex_rd, .ex_result, .ex_reg_write, .rs1, .rs2,
        .rdata1, .rdata2, .fwd_valid, .fwd_rd, .fwd_data, .wb_valid, .wb_rd, .wb_data
    );

endmodule

/* hw/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     src_a_pc;  // Operand A is pc.
        logic     src_b_imm; // Operand B is the immediate.
        br_cond_e br_cond;
        logic     jalr;      // Target is rs1 plus imm.
    } ex_ctrl_t;

    typedef struct packed {
        logic reg_write;
        logic link;          // Write pc+4 instead of the ALU result.
    } wb_ctrl_t;

    // All zero is a bubble.
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       data1;
        logic [xlen-1:0]       data2;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic                  predict_taken;
        logic [xlen-1:0]       predict_pc;
        ex_ctrl_t              ex_ctrl;
        wb_ctrl_t              wb_ctrl;
        logic                  valid;
    } id_ex_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
        logic                  reg_write;
        logic                  valid;
    } ex_wb_t;

endpackage

/* hw/pipe_stage.sv */
`timescale 1ns/100ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     stall,
    input  payload_t d,
    output payload_t q
);

    payload_t stage_q;

    // Flush only takes effect once the stall is released.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_q <= '0;
        end else if (flush && !stall) begin
            stage_q <= '0; // Insert a bubble.
        end else if (!stall) begin
            stage_q <= d;
        end
    end

    assign q = stage_q;

endmodule

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes handled by this slice.
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_e;

    // OP and OP-IMM funct3.
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // Branch funct3.
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Zero must stay add so a cleared payload is harmless.
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jump
    } br_cond_e;

endpackage

/* hw/writeback.sv */
`timescale 1ns/100ps

module writeback import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  stall,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic [xlen-1:0]       ex_result,
    input  logic                  ex_reg_write,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2,
    output logic                  fwd_valid,
    output logic [reg_addr_w-1:0] fwd_rd,
    output logic [xlen-1:0]       fwd_data,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data
);

    ex_wb_t          stage_d, stage_q;
    logic            we;
    logic [xlen-1:0] regs [32];

    assign stage_d = '{rd: ex_rd, result: ex_result, reg_write: ex_reg_write,
                       valid: ex_reg_write};

    pipe_stage #(.payload_t(ex_wb_t)) ex_wb (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (1'b0),
        .stall  (stall),
        .d      (stage_d),
        .q      (stage_q)
    );

    // Held stage during a stall must not write twice.
    assign we = stage_q.valid && stage_q.reg_write && stage_q.rd != '0 && !stall;

    always_ff @(posedge clk) begin
        if (we) regs[stage_q.rd] <= stage_q.result;
    end

    always_comb begin
        if (rs1 == '0) rdata1 = '0;
        else if (we && rs1 == stage_q.rd) rdata1 = stage_q.result; // Write-through.
        else rdata1 = regs[rs1];
        if (rs2 == '0) rdata2 = '0;
        else if (we && rs2 == stage_q.rd) rdata2 = stage_q.result;
        else rdata2 = regs[rs2];
    end

    assign fwd_valid = stage_q.valid && stage_q.reg_write;
    assign fwd_rd    = stage_q.rd;
    assign fwd_data  = stage_q.result;

    assign wb_valid = we;
    assign wb_rd    = stage_q.rd;
    assign wb_data  = stage_q.result;

endmodule

/* tests/issue_vectors.hex */
// valid_instr_pc_predtaken_predpc_stall _ redirect_redirectpc_wbvalid_wbrd_wbdata
// redirect_pc is compared only when redirect is set, wb_rd and wb_data only with wb_valid.
0_00000000_00000000_0_00000000_0_0_00000000_0_00_00000000
1_00500093_00000100_0_00000000_0_0_00000000_0_00_00000000
1_00308113_00000104_0_00000000_0_0_00000000_0_00_00000000
1_002081B3_00000108_0_00000000_0_0_00000000_1_01_00000005
1_12345237_0000010C_0_00000000_0_0_00000000_1_02_00000008
1_00001297_00000110_0_00000000_0_0_00000000_1_03_0000000D
1_00708013_00000114_0_00000000_0_0_00000000_1_04_12345000
1_40118333_00000118_0_00000000_0_0_00000000_1_05_00001110
1_40135393_0000011C_0_00000000_0_0_00000000_0_00_00000000
1_00108863_00000120_1_00000130_0_0_00000000_1_06_00000008
1_00209463_00000130_0_00000000_0_0_00000000_1_07_00000004
1_06300413_00000134_0_00000000_0_1_00000138_0_00_00000000
1_010004EF_00000138_1_00000148_0_0_00000000_0_00_00000000
1_04008567_00000148_1_00000100_0_0_00000000_0_00_00000000
1_00100593_0000014C_0_00000000_0_1_00000044_1_09_0000013C
1_00448613_00000044_0_00000000_0_0_00000000_1_0A_0000014C
1_00160693_00000048_0_00000000_0_0_00000000_0_00_00000000
1_00C68733_0000004C_0_00000000_1_0_00000000_0_00_00000000
1_00C68733_0000004C_0_00000000_0_0_00000000_1_0C_00000140
1_FFF00793_00000050_0_00000000_0_0_00000000_1_0D_00000141
1_00F0B833_00000054_0_00000000_0_0_00000000_1_0E_00000281
1_FE17CCE3_00000058_1_00000050_0_0_00000000_1_0F_FFFFFFFF
1_00F0F463_00000050_1_00000058_0_0_00000000_1_10_00000001
1_00100893_00000058_0_00000000_0_1_00000054_0_00_00000000
0_00000000_00000000_0_00000000_0_0_00000000_0_00_00000000
0_00000000_00000000_0_00000000_0_0_00000000_0_00_00000000
0_00000000_00000000_0_00000000_0_0_00000000_0_00_00000000

/* tests/tb_issue_execute.sv */
`timescale 1ns/100ps

module tb_issue_execute;

    localparam int num_vectors = 27;
    localparam int reset_cycles = 3;
    localparam int cycle_limit = num_vectors + reset_cycles + 20;

    logic        clk;
    logic        arst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        predict_taken;
    logic [31:0] predict_pc;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // One record per cycle. Column layout is in the hex file header.
    logic [187:0] vectors [0:num_vectors-1];
    logic [187:0] rec;
    int           cycle_count;

    issue_execute uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .pc            (pc),
        .predict_taken (predict_taken),
        .predict_pc    (predict_pc),
        .stall         (stall),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    always #2 clk = ~clk;

    // Hard stop in case the pipeline or the loop never finishes.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Run did not finish within %0d cycles.", cycle_limit);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        instr_valid   = 1'b0;
        instr         = '0;
        pc            = '0;
        predict_taken = 1'b0;
        predict_pc    = '0;
        stall         = 1'b0;
        cycle_count   = 0;
        rec           = '0;

        $readmemh("tests/issue_vectors.hex", vectors);

        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;

        for (int k = 0; k < num_vectors; k++) begin
            @(posedge clk);
            rec = vectors[k];
            instr_valid   <= rec[184];
            instr         <= rec[183:152];
            pc            <= rec[151:120];
            predict_taken <= rec[116];
            predict_pc    <= rec[115:84];
            stall         <= rec[80];

            // Outputs have settled by the falling edge.
            @(negedge clk);
            check_value("redirect", 32'(redirect), 32'(rec[76]));
            if (rec[76]) begin
                check_value("redirect_pc", redirect_pc, rec[75:44]);
            end
            check_value("wb_valid", 32'(wb_valid), 32'(rec[40]));
            if (rec[40]) begin
                check_value("wb_rd", 32'(wb_rd), 32'(rec[36:32]));
                check_value("wb_data", wb_data, rec[31:0]);
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule
